//--- source/robPkg.sv
package robPkg;

    // widest tag the buffer can hand out
    localparam int robTagW = 5;

    typedef logic [4:0]  regIdxT;   // x0 is hardwired zero
    typedef logic [31:0] dataT;
    typedef logic [31:0] addrT;

    typedef enum logic [1:0] {
        opAlu    = 2'd0,
        opStore  = 2'd1,
        opBranch = 2'd2
    } robOpT;

    // dispatch request in program order
    typedef struct packed {
        robOpT  op;
        regIdxT rd;
        regIdxT src1;
        regIdxT src2;
        logic   predTaken;   // front end guess for branches
        addrT   pc;
    } dispatchT;

    // writeback from the execution side in any order
    typedef struct packed {
        logic               valid;
        logic [robTagW-1:0] tag;
        dataT               data;
        logic               taken;    // actual direction
        addrT               target;   // taken target
    } resultT;

    // one retirement per cycle in tag order
    typedef struct packed {
        logic               valid;
        robOpT              op;
        regIdxT             rd;
        logic [robTagW-1:0] tag;
        dataT               data;
    } retireT;

endpackage

//--- source/reorderBuffer.sv
module reorderBuffer #(
    parameter int robDepth = 16
) (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       dispValid,
    input  robPkg::dispatchT           dispatch,
    output logic                       dispReady,
    output logic [robPkg::robTagW-1:0] dispTag,
    input  robPkg::resultT             result,
    output robPkg::retireT             retire,
    output logic                       flush,
    output robPkg::addrT               redirectPc
);
    import robPkg::*;

    localparam int idxW = $clog2(robDepth);

    // per-slot payload filled at dispatch and at writeback
    typedef struct packed {
        robOpT  op;
        regIdxT rd;
        logic   predTaken;
        addrT   pc;
        dataT   data;
        logic   taken;
        addrT   target;
    } entryT;

    entryT               entries [robDepth];
    logic [robDepth-1:0] entryValid;
    logic [robDepth-1:0] entryDone;

    // extra msb tells full from empty
    logic [idxW:0]   head;
    logic [idxW:0]   tail;
    logic [idxW-1:0] headIdx;
    logic [idxW-1:0] tailIdx;
    logic [idxW-1:0] resIdx;

    logic  full;
    logic  accept;
    logic  resHit;
    logic  canRetire;
    logic  mispredict;
    entryT headEntry;

    assign headIdx = head[idxW-1:0];
    assign tailIdx = tail[idxW-1:0];
    assign resIdx  = result.tag[idxW-1:0];

    assign full      = (headIdx == tailIdx) && (head[idxW] != tail[idxW]);
    assign dispReady = !full && !flush;   // one dead cycle after a flush
    assign dispTag   = robTagW'(tailIdx);
    assign accept    = dispValid && dispReady;

    // results for slots not in flight are dropped
    assign resHit = result.valid && entryValid[resIdx];

    assign headEntry  = entries[headIdx];
    assign canRetire  = entryValid[headIdx] && entryDone[headIdx];
    assign mispredict = canRetire && (headEntry.op == opBranch) &&
                        (headEntry.taken != headEntry.predTaken);

    // pointers, slot state and retirement outputs
    always_ff @(posedge clk) begin
        if (rst) begin
            head         <= '0;
            tail         <= '0;
            entryValid   <= '0;
            entryDone    <= '0;
            flush        <= 1'b0;
            retire.valid <= 1'b0;
        end else begin
            flush        <= mispredict;
            retire.valid <= canRetire;

            if (accept) begin
                entryValid[tailIdx] <= 1'b1;
                entryDone[tailIdx]  <= 1'b0;
                tail                <= tail + 1'b1;
            end

            if (resHit) begin
                entryDone[resIdx] <= 1'b1;
            end

            if (canRetire) begin
                entryValid[headIdx] <= 1'b0;
                head                <= head + 1'b1;
                retire.op           <= headEntry.op;
                retire.rd           <= headEntry.rd;
                retire.tag          <= robTagW'(headIdx);
                retire.data         <= headEntry.data;
                redirectPc          <= headEntry.taken ? headEntry.target
                                                       : headEntry.pc + 32'd4;
            end

            // wrong path drops everything younger including a same-edge dispatch
            if (mispredict) begin
                entryValid <= '0;
                tail       <= head + 1'b1;
            end
        end
    end

    // slot payload
    always_ff @(posedge clk) begin
        if (accept) begin
            entries[tailIdx].op        <= dispatch.op;
            entries[tailIdx].rd        <= dispatch.rd;
            entries[tailIdx].predTaken <= dispatch.predTaken;
            entries[tailIdx].pc        <= dispatch.pc;
        end
        if (resHit) begin
            entries[resIdx].data   <= result.data;
            entries[resIdx].taken  <= result.taken;
            entries[resIdx].target <= result.target;
        end
    end

endmodule

//--- source/renameTable.sv
module renameTable #(
    parameter int robDepth = 16
) (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       dispValid,
    input  logic                       dispReady,
    input  robPkg::dispatchT           dispatch,
    input  logic [robPkg::robTagW-1:0] dispTag,
    input  robPkg::retireT             retire,
    input  logic                       flush,
    output logic                       src1Busy,
    output logic [robPkg::robTagW-1:0] src1Tag,
    output logic                       src2Busy,
    output logic [robPkg::robTagW-1:0] src2Tag
);
    import robPkg::*;

    localparam int idxW    = $clog2(robDepth);
    localparam int numRegs = 2 ** $bits(regIdxT);

    logic [numRegs-1:0] busy;
    logic [idxW-1:0]    writer [numRegs];   // youngest pending producer

    logic recordDisp;
    logic clearRetire;

    // only ALU ops produce a register value
    assign recordDisp = dispValid && dispReady && (dispatch.op == opAlu) &&
                        (dispatch.rd != '0);

    // clear only if no younger writer took over the register
    assign clearRetire = retire.valid && (retire.op == opAlu) && busy[retire.rd] &&
                         (writer[retire.rd] == retire.tag[idxW-1:0]);

    // lookups see the table before this cycle's dispatch
    assign src1Busy = busy[dispatch.src1];
    assign src1Tag  = robTagW'(writer[dispatch.src1]);
    assign src2Busy = busy[dispatch.src2];
    assign src2Tag  = robTagW'(writer[dispatch.src2]);

    always_ff @(posedge clk) begin
        if (rst || flush) begin
            busy <= '0;
        end else begin
            if (clearRetire) begin
                busy[retire.rd] <= 1'b0;
            end
            if (recordDisp) begin   // dispatch wins on the same register
                busy[dispatch.rd] <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (recordDisp) begin
            writer[dispatch.rd] <= dispTag[idxW-1:0];
        end
    end

endmodule

//--- source/archRegFile.sv
module archRegFile (
    input  logic           clk,
    input  logic           rst,
    input  robPkg::retireT retire,
    input  logic           psel,
    input  logic           penable,
    input  logic           pwrite,
    input  robPkg::regIdxT paddr,
    output robPkg::dataT   prdata,
    output logic           pready,
    output logic           pslverr
);
    import robPkg::*;

    localparam int numRegs = 2 ** $bits(regIdxT);

    dataT regs [numRegs];

    logic accessPhase;
    logic regWrite;

    assign accessPhase = psel && penable;

    // x0 is never written so it stays at its reset value
    assign regWrite = retire.valid && (retire.op == opAlu) && (retire.rd != '0);

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < numRegs; i++) begin
                regs[i] <= '0;
            end
        end else if (regWrite) begin
            regs[retire.rd] <= retire.data;
        end
    end

    // APB side is read only with no wait states
    assign pready  = 1'b1;
    assign prdata  = (accessPhase && !pwrite) ? regs[paddr] : '0;
    assign pslverr = accessPhase && pwrite;   // writes belong to retirement

endmodule

//--- source/robCore.sv
module robCore #(
    parameter int robDepth = 16
) (
    input  logic                       clk,
    input  logic                       rst,

    // dispatch
    input  logic                       dispValid,
    input  robPkg::dispatchT           dispatch,
    output logic                       dispReady,
    output logic [robPkg::robTagW-1:0] dispTag,

    // source lookup
    output logic                       src1Busy,
    output logic [robPkg::robTagW-1:0] src1Tag,
    output logic                       src2Busy,
    output logic [robPkg::robTagW-1:0] src2Tag,

    // writeback and retirement
    input  robPkg::resultT             result,
    output robPkg::retireT             retire,
    output logic                       flush,
    output robPkg::addrT               redirectPc,

    // APB readback of the register file
    input  logic                       psel,
    input  logic                       penable,
    input  logic                       pwrite,
    input  robPkg::regIdxT             paddr,
    output robPkg::dataT               prdata,
    output logic                       pready,
    output logic                       pslverr
);

    reorderBuffer #(
        .robDepth(robDepth)
    ) rob (
        .clk       (clk),
        .rst       (rst),
        .dispValid (dispValid),
        .dispatch  (dispatch),
        .dispReady (dispReady),
        .dispTag   (dispTag),
        .result    (result),
        .retire    (retire),
        .flush     (flush),
        .redirectPc(redirectPc)
    );

    renameTable #(
        .robDepth(robDepth)
    ) rename (
        .clk      (clk),
        .rst      (rst),
        .dispValid(dispValid),
        .dispReady(dispReady),
        .dispatch (dispatch),
        .dispTag  (dispTag),
        .retire   (retire),
        .flush    (flush),
        .src1Busy (src1Busy),
        .src1Tag  (src1Tag),
        .src2Busy (src2Busy),
        .src2Tag  (src2Tag)
    );

    archRegFile regFile (
        .clk    (clk),
        .rst    (rst),
        .retire (retire),
        .psel   (psel),
        .penable(penable),
        .pwrite (pwrite),
        .paddr  (paddr),
        .prdata (prdata),
        .pready (pready),
        .pslverr(pslverr)
    );

endmodule

//--- dv/robRef.svh
`ifndef ROB_REF_SVH
`define ROB_REF_SVH

// one in-flight instruction as the model sees it
typedef struct packed {
    logic [robTagW-1:0] tag;
    robOpT              op;
    regIdxT             rd;
    dataT               data;       // result chosen at dispatch
    logic               predTaken;
    logic               taken;
    addrT               pc;
    addrT               target;
} modelEntryT;

modelEntryT         robModel[$];      // program order, oldest first
logic [robTagW-1:0] pendingTags[$];   // dispatched, result not yet sent
dataT               modelRegs [32] = '{default: '0};
int                 nextTag = 0;
logic [31:0]        lcgState = 32'd58;

function automatic logic [15:0] randBits();
    lcgState = lcgState * 32'd1664525 + 32'd1013904223;
    return lcgState[31:16];   // low bits of an LCG repeat too soon
endfunction

function automatic modelEntryT newInstr(bit mixed);
    modelEntryT e;
    int         kind;
    kind = int'(randBits() % 8);
    if (!mixed || kind < 5) begin
        e.op = opAlu;
    end else if (kind < 7) begin
        e.op = opStore;
    end else begin
        e.op = opBranch;
    end
    e.tag       = robTagW'(nextTag);
    e.rd        = regIdxT'(randBits());
    e.data      = {randBits(), randBits()};
    e.predTaken = (randBits() > 16'h7fff);
    e.taken     = (randBits() > 16'h7fff);
    e.pc        = {randBits(), randBits()} & ~32'h3;
    e.target    = {randBits(), randBits()} & ~32'h3;
    return e;
endfunction

function automatic bit isMispredict(modelEntryT e);
    return (e.op == opBranch) && (e.taken != e.predTaken);
endfunction

function automatic addrT expectedRedirect(modelEntryT e);
    return e.taken ? e.target : e.pc + 32'd4;
endfunction

function automatic retireT expectedRetire(modelEntryT e);
    retireT r;
    r.valid = 1'b1;
    r.op    = e.op;
    r.rd    = e.rd;
    r.tag   = e.tag;
    r.data  = e.data;
    return r;
endfunction

// youngest in-flight ALU writer of r with the busy bit on top
function automatic logic [robTagW:0] pendingWriter(regIdxT r);
    for (int i = robModel.size() - 1; i >= 0; i--) begin
        if (robModel[i].op == opAlu && robModel[i].rd == r && r != '0) begin
            return {1'b1, robModel[i].tag};
        end
    end
    return '0;
endfunction

function automatic int findEntry(logic [robTagW-1:0] tag);
    foreach (robModel[i]) begin
        if (robModel[i].tag == tag) begin
            return i;
        end
    end
    return -1;
endfunction

`endif

//--- dv/robTb.sv
module robTb;
    timeunit 1ns;
    timeprecision 100ps;

    import robPkg::*;

    localparam int robDepth   = 16;
    localparam int clkPeriod  = 100;
    localparam int numRandom  = 320;
    localparam int totalInstr = robDepth + numRandom;

    logic               clk;
    logic               rst;
    logic               dispValid;
    dispatchT           dispatch;
    logic               dispReady;
    logic [robTagW-1:0] dispTag;
    logic               src1Busy;
    logic [robTagW-1:0] src1Tag;
    logic               src2Busy;
    logic [robTagW-1:0] src2Tag;
    resultT             result;
    retireT             retire;
    logic               flush;
    addrT               redirectPc;
    logic               psel;
    logic               penable;
    logic               pwrite;
    regIdxT             paddr;
    dataT               prdata;
    logic               pready;
    logic               pslverr;

    int flushCount   = 0;
    int goodBranches = 0;

    `include "robRef.svh"

    robCore #(
        .robDepth(robDepth)
    ) DUT (
        .clk       (clk),
        .rst       (rst),
        .dispValid (dispValid),
        .dispatch  (dispatch),
        .dispReady (dispReady),
        .dispTag   (dispTag),
        .src1Busy  (src1Busy),
        .src1Tag   (src1Tag),
        .src2Busy  (src2Busy),
        .src2Tag   (src2Tag),
        .result    (result),
        .retire    (retire),
        .flush     (flush),
        .redirectPc(redirectPc),
        .psel      (psel),
        .penable   (penable),
        .pwrite    (pwrite),
        .paddr     (paddr),
        .prdata    (prdata),
        .pready    (pready),
        .pslverr   (pslverr)
    );

    initial begin
        clk = 1'b0;
        forever #(clkPeriod / 2) clk = ~clk;
    end

    task automatic stopWithFailure(input string why);
        $display("%s", why);
        $display("sim failed");
        $fatal(1);
    endtask

    task automatic reportMismatch(input string msg);
        stopWithFailure($sformatf("mismatch at %0d ns: %s", $time, msg));
    endtask

    // one clock of stimulus with an optional writeback and dispatch and a lookup check
    task automatic driveCycle(input bit doDispatch, input bit doResult, input bit mixed);
        modelEntryT         e;
        int                 pick;
        logic [robTagW:0]   look1;
        logic [robTagW:0]   look2;
        @(negedge clk);
        dispValid    = 1'b0;
        result.valid = 1'b0;
        if (doResult && pendingTags.size() > 0 && randBits() % 4 != 0) begin
            pick          = int'(randBits()) % pendingTags.size();
            e             = robModel[findEntry(pendingTags[pick])];
            result.valid  = 1'b1;
            result.tag    = e.tag;
            result.data   = e.data;
            result.taken  = e.taken;
            result.target = e.target;
            pendingTags.delete(pick);
        end
        dispatch.src1 = regIdxT'(randBits());
        dispatch.src2 = regIdxT'(randBits());
        look1 = pendingWriter(dispatch.src1);   // table before this dispatch
        look2 = pendingWriter(dispatch.src2);
        if (doDispatch && dispReady) begin
            e = newInstr(mixed);
            assert (dispTag == e.tag)
                else reportMismatch($sformatf("dispTag %0d, expected %0d", dispTag, e.tag));
            dispatch.op        = e.op;
            dispatch.rd        = e.rd;
            dispatch.predTaken = e.predTaken;
            dispatch.pc        = e.pc;
            dispValid          = 1'b1;
            robModel.push_back(e);
            pendingTags.push_back(e.tag);
            nextTag = (nextTag + 1) % robDepth;
        end
        #1;
        assert (src1Busy == look1[robTagW] && (!src1Busy || src1Tag == look1[robTagW-1:0]))
            else reportMismatch($sformatf("src1 x%0d busy %0b tag %0d, expected %0b tag %0d",
                dispatch.src1, src1Busy, src1Tag, look1[robTagW], look1[robTagW-1:0]));
        assert (src2Busy == look2[robTagW] && (!src2Busy || src2Tag == look2[robTagW-1:0]))
            else reportMismatch($sformatf("src2 x%0d busy %0b tag %0d, expected %0b tag %0d",
                dispatch.src2, src2Busy, src2Tag, look2[robTagW], look2[robTagW-1:0]));
    endtask

    task automatic apbAccess(input bit write, input regIdxT addr, output dataT rdata,
                             output logic err);
        @(negedge clk);
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = write;
        paddr   = addr;
        @(negedge clk);
        penable = 1'b1;   // access phase
        @(posedge clk);
        assert (pready) else stopWithFailure("APB pready was low in the access phase");
        rdata = prdata;
        err   = pslverr;
        @(negedge clk);
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
    endtask

    // retirement checker
    always @(posedge clk) begin
        modelEntryT front;
        if (!rst && retire.valid) begin
            assert (robModel.size() > 0)
                else stopWithFailure("an instruction retired with nothing in flight");
            front = robModel.pop_front();
            assert (retire == expectedRetire(front))
                else reportMismatch($sformatf("retire tag %0d op %0d rd %0d data %h, expected tag %0d op %0d rd %0d data %h",
                    retire.tag, retire.op, retire.rd, retire.data,
                    front.tag, front.op, front.rd, front.data));
            assert (flush == isMispredict(front))
                else reportMismatch($sformatf("flush %0b on retire of tag %0d", flush, front.tag));
            if (front.op == opAlu && front.rd != '0) begin
                modelRegs[front.rd] = front.data;
            end
            if (isMispredict(front)) begin
                assert (redirectPc == expectedRedirect(front))
                    else reportMismatch($sformatf("redirectPc %h, expected %h",
                        redirectPc, expectedRedirect(front)));
                robModel.delete();      // wrong path is gone
                pendingTags.delete();
                nextTag = (int'(front.tag) + 1) % robDepth;
                flushCount++;
            end else if (front.op == opBranch) begin
                goodBranches++;
            end
        end else if (!rst) begin
            assert (!flush) else reportMismatch("flush without a retiring branch");
        end
    end

    initial begin
        #(totalInstr * 40 * clkPeriod);
        stopWithFailure("timeout: the run did not finish in time");
    end

    initial begin
        dataT rdata;
        logic err;
        rst       = 1'b1;
        dispValid = 1'b0;
        dispatch  = '0;
        result    = '0;
        psel      = 1'b0;
        penable   = 1'b0;
        pwrite    = 1'b0;
        paddr     = '0;
        repeat (3) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        assert (!retire.valid && !flush && dispReady && !pslverr)
            else reportMismatch("outputs not idle after reset");

        // fill with no writebacks
        repeat (robDepth) driveCycle(1'b1, 1'b0, 1'b0);
        @(negedge clk);
        dispValid = 1'b0;
        assert (!dispReady && robModel.size() == robDepth)
            else reportMismatch($sformatf("dispReady %0b with %0d in flight", dispReady,
                robModel.size()));
        while (!dispReady) driveCycle(1'b0, 1'b1, 1'b0);
        assert (retire.valid) else reportMismatch("dispReady rose without a retirement");

        repeat (numRandom) driveCycle(randBits() % 4 != 0, 1'b1, 1'b1);
        while (robModel.size() > 0) driveCycle(1'b0, 1'b1, 1'b1);
        @(negedge clk);
        dispValid    = 1'b0;
        result.valid = 1'b0;

        for (int i = 0; i < 32; i++) begin
            apbAccess(1'b0, regIdxT'(i), rdata, err);
            assert (rdata == modelRegs[i] && !err)
                else reportMismatch($sformatf("x%0d read %h err %0b, expected %h", i, rdata,
                    err, modelRegs[i]));
        end
        apbAccess(1'b1, regIdxT'(3), rdata, err);
        assert (err) else reportMismatch("APB write returned no pslverr");

        if (flushCount > 0 && goodBranches > 0) begin
            $display("sim passed");
            $finish;
        end else begin
            stopWithFailure("the random run retired no mispredicted or no correct branch");
        end
    end

endmodule

//--- list.f
+incdir+dv
source/robPkg.sv
source/reorderBuffer.sv
source/renameTable.sv
source/archRegFile.sv
source/robCore.sv
dv/robTb.sv

//--- Makefile
TOP = robTb

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert -f list.f --top-module $(TOP)

run: build
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "sim passed"

lint:
	verilator --lint-only --timing --assert -f list.f --top-module $(TOP)

clean:
	rm -rf obj_dir
